/* logic/pwmPkg.sv */
package pwmPkg;

	// in-device address space
	localparam int localAddrWidth = 12;

	// prescale shift amount, 0 to 31
	localparam int scaleWidth = 5;

	// register map
	localparam logic [localAddrWidth-1:0] addrConfig = 12'h000;
	localparam logic [localAddrWidth-1:0] addrTop = 12'h004;
	localparam logic [localAddrWidth-1:0] addrData = 12'h008;

	// compare registers, one word per channel
	localparam logic [localAddrWidth-1:0] addrCompareBase = 12'h010;
	localparam logic [localAddrWidth-1:0] addrCompareStride = 12'h004;

	// reset values
	localparam int defaultScale = 3;

	// 5000 counts per period with the default prescale
	localparam int defaultTop = 'h1387;

	// returned when nothing claims a read
	localparam logic [31:0] readIdle = 32'hffff_ffff;

	typedef logic [scaleWidth-1:0] scaleT;

endpackage

/* logic/busRegister.sv */
`timescale 1ns/1ps

module busRegister #(
	parameter type payloadT = logic [31:0],
	parameter logic [pwmPkg::localAddrWidth-1:0] address = '0,
	parameter payloadT resetValue = '0
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic busWe,
	input logic busOe,
	input logic [pwmPkg::localAddrWidth-1:0] localAddress,
	input logic [3:0] busByteSelect,
	input logic [31:0] busDataWrite,
	output logic [31:0] readData,
	output logic readRequest,
	output payloadT value
);

	localparam int payloadWidth = $bits(payloadT);

	logic addressMatch;
	logic [31:0] currentWord;
	logic [31:0] laneMask;
	logic [31:0] mergedWord;

	assign addressMatch = enable && (localAddress == address);
	assign readRequest = addressMatch && busOe;

	// payload zero-extended to the bus word
	assign currentWord = 32'(value);

	// one mask byte per selected lane
	assign laneMask = {
		{8{busByteSelect[3]}},
		{8{busByteSelect[2]}},
		{8{busByteSelect[1]}},
		{8{busByteSelect[0]}}
	};
	assign mergedWord = (busDataWrite & laneMask) | (currentWord & ~laneMask);

	assign readData = readRequest ? currentWord : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= resetValue;
		end else if (addressMatch && busWe) begin
			// bits above the payload are dropped
			value <= payloadT'(mergedWord[payloadWidth-1:0]);
		end
	end

endmodule

/* logic/pwmTimebase.sv */
`timescale 1ns/1ps

module pwmTimebase #(
	parameter int WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic counterEnable,
	input pwmPkg::scaleT scale,
	input logic [WIDTH-1:0] topValue,
	input logic topWrite,
	output logic [WIDTH-1:0] counterValue
);

	import pwmPkg::*;

	// room for the full shift range on top of the visible count
	localparam int baseWidth = WIDTH + 2**scaleWidth;

	logic [baseWidth-1:0] baseCounter;
	logic [baseWidth-1:0] shiftedCount;
	logic [baseWidth-1:0] fractionMask;
	logic lastTick;
	logic pastTop;

	assign shiftedCount = baseCounter >> scale;
	assign counterValue = shiftedCount[WIDTH-1:0];

	// low bits below the visible count
	assign fractionMask = ~({baseWidth{1'b1}} << scale);

	// last base clock of the top count, so the period is (top+1) << scale
	assign lastTick = (shiftedCount == baseWidth'(topValue))
		&& ((baseCounter & fractionMask) == fractionMask);

	// a smaller prescale can leave the view above top
	assign pastTop = shiftedCount > baseWidth'(topValue);

	always_ff @(posedge clk) begin
		if (rst) begin
			baseCounter <= '0;
		end else if (topWrite || !counterEnable) begin
			baseCounter <= '0;
		end else if (lastTick || pastTop) begin
			baseCounter <= '0;
		end else begin
			baseCounter <= baseCounter + 1'b1;
		end
	end

	// holds once the counter has had a cycle to restart after a change
	assert property (@(posedge clk) disable iff (rst)
		(counterEnable && !topWrite && $stable(scale)) |-> (counterValue <= topValue));

endmodule

/* logic/pwmChannel.sv */
`timescale 1ns/1ps

module pwmChannel #(
	parameter int WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic [WIDTH-1:0] counterValue,
	input logic [WIDTH-1:0] compareValue,
	output logic pwmOut,
	output logic rise,
	output logic fall
);

	logic compareHit;

	// high for the first compareValue counts of each period
	assign compareHit = enable && (counterValue < compareValue);

	always_ff @(posedge clk) begin
		if (rst) begin
			pwmOut <= 1'b0;
			rise <= 1'b0;
			fall <= 1'b0;
		end else begin
			pwmOut <= compareHit;
			// events line up with the cycle pwmOut takes its new level
			rise <= compareHit && !pwmOut;
			fall <= !compareHit && pwmOut;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!(rise && fall));

endmodule

/* logic/pwmBusInterface.sv */
`timescale 1ns/1ps

module pwmBusInterface #(
	parameter logic [3:0] ID = 4'h0,
	parameter int OUTPUTS = 4,
	parameter int WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic peripheralEnable,
	input logic busWe,
	input logic busOe,
	input logic [15:0] busAddress,
	input logic [3:0] busByteSelect,
	input logic [31:0] busDataWrite,
	input logic [OUTPUTS-1:0][31:0] channelRead,
	input logic [OUTPUTS-1:0] channelRequest,
	input logic [31:0] configRead,
	input logic configRequest,
	input logic [WIDTH-1:0] counterValue,
	input logic [OUTPUTS-1:0] pwmOut,
	output logic [pwmPkg::localAddrWidth-1:0] localAddress,
	output logic deviceEnable,
	output logic [WIDTH-1:0] topValue,
	output logic topWrite,
	output logic [31:0] busDataRead,
	output logic requestOutput
);

	import pwmPkg::*;

	logic topHit;
	logic dataHit;
	logic topRequest;
	logic dataRequest;
	logic [31:0] topWord;
	logic [31:0] topMerged;
	logic [WIDTH+OUTPUTS-1:0] dataSample;

	// upper nibble selects the device
	assign localAddress = busAddress[localAddrWidth-1:0];
	assign deviceEnable = peripheralEnable && (busAddress[15:12] == ID);

	assign topHit = deviceEnable && (localAddress == addrTop);
	assign dataHit = deviceEnable && (localAddress == addrData);
	assign topRequest = topHit && busOe;
	assign dataRequest = dataHit && busOe;

	assign topWord = 32'(topValue);

	always_comb begin
		topMerged = topWord;
		for (int b = 0; b < 4; b++) begin
			if (busByteSelect[b]) begin
				topMerged[8*b +: 8] = busDataWrite[8*b +: 8];
			end
		end
	end

	// topWrite restarts the timebase in the cycle the new top appears
	always_ff @(posedge clk) begin
		if (rst) begin
			topValue <= WIDTH'(defaultTop);
			topWrite <= 1'b0;
		end else begin
			topWrite <= topHit && busWe;
			if (topHit && busWe) begin
				topValue <= topMerged[WIDTH-1:0];
			end
		end
	end

	// read-only snapshot, one cycle behind the pins
	always_ff @(posedge clk) begin
		dataSample <= {pwmOut, counterValue};
	end

	assign requestOutput = configRequest || topRequest || dataRequest || (|channelRequest);

	always_comb begin
		busDataRead = readIdle;
		if (configRequest) begin
			busDataRead = configRead;
		end else if (topRequest) begin
			busDataRead = topWord;
		end else if (dataRequest) begin
			busDataRead = 32'(dataSample);
		end else begin
			// lowest channel wins
			for (int i = OUTPUTS - 1; i >= 0; i--) begin
				if (channelRequest[i]) begin
					busDataRead = channelRead[i];
				end
			end
		end
	end

	// register addresses must never overlap
	assert property (@(posedge clk) disable iff (rst)
		$onehot0({channelRequest, configRequest, topRequest, dataRequest}));

endmodule

/* logic/pwmDevice.sv */
`timescale 1ns/1ps

module pwmDevice #(
	parameter logic [3:0] ID = 4'h0,
	parameter int OUTPUTS = 4,
	parameter int WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input logic peripheralEnable,
	input logic busWe,
	input logic busOe,
	input logic [15:0] busAddress,
	input logic [3:0] busByteSelect,
	input logic [31:0] busDataWrite,
	output logic [31:0] busDataRead,
	output logic requestOutput,
	output logic [OUTPUTS-1:0] pwmEn,
	output logic [OUTPUTS-1:0] pwmOut,
	output logic irq
);

	import pwmPkg::*;

	// scale, counter enable, then compare, output, rise and fall enables
	localparam int configWidth = scaleWidth + 1 + 4 * OUTPUTS;

	typedef logic [configWidth-1:0] configT;
	typedef logic [WIDTH-1:0] compareT;

	logic [localAddrWidth-1:0] localAddress;
	logic deviceEnable;
	logic [WIDTH-1:0] topValue;
	logic topWrite;
	logic [WIDTH-1:0] counterValue;
	configT configuration;
	logic [31:0] configRead;
	logic configRequest;
	logic [OUTPUTS-1:0][31:0] channelRead;
	logic [OUTPUTS-1:0] channelRequest;
	scaleT scale;
	logic counterEnable;
	logic [OUTPUTS-1:0] compareEnable;
	logic [OUTPUTS-1:0] outputEnable;
	logic [OUTPUTS-1:0] riseIrqEnable;
	logic [OUTPUTS-1:0] fallIrqEnable;
	logic [OUTPUTS-1:0] rise;
	logic [OUTPUTS-1:0] fall;

	pwmBusInterface #(.ID(ID), .OUTPUTS(OUTPUTS), .WIDTH(WIDTH)) busInterface (
		.clk(clk), .rst(rst), .peripheralEnable(peripheralEnable),
		.busWe(busWe), .busOe(busOe), .busAddress(busAddress),
		.busByteSelect(busByteSelect), .busDataWrite(busDataWrite),
		.channelRead(channelRead), .channelRequest(channelRequest),
		.configRead(configRead), .configRequest(configRequest),
		.counterValue(counterValue), .pwmOut(pwmOut),
		.localAddress(localAddress), .deviceEnable(deviceEnable),
		.topValue(topValue), .topWrite(topWrite),
		.busDataRead(busDataRead), .requestOutput(requestOutput)
	);

	busRegister #(
		.payloadT(configT),
		.address(addrConfig),
		.resetValue(configT'(defaultScale))
	) configRegister (
		.clk(clk), .rst(rst), .enable(deviceEnable), .busWe(busWe), .busOe(busOe),
		.localAddress(localAddress), .busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite), .readData(configRead),
		.readRequest(configRequest), .value(configuration)
	);

	assign scale = configuration[scaleWidth-1:0];
	assign counterEnable = configuration[scaleWidth];
	assign compareEnable = configuration[scaleWidth + 1 +: OUTPUTS];
	assign outputEnable = configuration[scaleWidth + 1 + OUTPUTS +: OUTPUTS];
	assign riseIrqEnable = configuration[scaleWidth + 1 + 2 * OUTPUTS +: OUTPUTS];
	assign fallIrqEnable = configuration[scaleWidth + 1 + 3 * OUTPUTS +: OUTPUTS];

	pwmTimebase #(.WIDTH(WIDTH)) timebase (
		.clk(clk), .rst(rst), .counterEnable(counterEnable), .scale(scale),
		.topValue(topValue), .topWrite(topWrite), .counterValue(counterValue)
	);

	for (genvar i = 0; i < OUTPUTS; i++) begin : channel
		compareT compareValue;

		busRegister #(
			.payloadT(compareT),
			.address(addrCompareBase + localAddrWidth'(i * addrCompareStride)),
			.resetValue('0)
		) compareRegister (
			.clk(clk), .rst(rst), .enable(deviceEnable), .busWe(busWe), .busOe(busOe),
			.localAddress(localAddress), .busByteSelect(busByteSelect),
			.busDataWrite(busDataWrite), .readData(channelRead[i]),
			.readRequest(channelRequest[i]), .value(compareValue)
		);

		pwmChannel #(.WIDTH(WIDTH)) outputChannel (
			.clk(clk), .rst(rst), .enable(compareEnable[i]),
			.counterValue(counterValue), .compareValue(compareValue),
			.pwmOut(pwmOut[i]), .rise(rise[i]), .fall(fall[i])
		);
	end

	assign pwmEn = compareEnable & outputEnable;

	// any enabled edge event on any channel
	assign irq = |((riseIrqEnable & rise) | (fallIrqEnable & fall));

endmodule

/* testbench/pwmDeviceTb.sv */
`timescale 1ns/1ps

module pwmDeviceTb;

	import pwmPkg::*;

	localparam logic [3:0] ID = 4'h3;
	localparam int OUTPUTS = 4;
	localparam int WIDTH = 16;
	localparam logic [31:0] configMask = 32'((64'd1 << (scaleWidth + 1 + 4 * OUTPUTS)) - 1);

	logic clk;
	logic rst;
	logic peripheralEnable;
	logic busWe;
	logic busOe;
	logic [15:0] busAddress;
	logic [3:0] busByteSelect;
	logic [31:0] busDataWrite;
	logic [31:0] busDataRead;
	logic requestOutput;
	logic [OUTPUTS-1:0] pwmEn;
	logic [OUTPUTS-1:0] pwmOut;
	logic irq;

	// shadow registers of the reference model
	logic [31:0] shadowConfig;
	logic [31:0] shadowTop;
	logic [31:0] shadowCompare [OUTPUTS];
	logic [OUTPUTS-1:0] prevPwm;
	logic [OUTPUTS-1:0] lastRise;

	pwmDevice #(.ID(ID), .OUTPUTS(OUTPUTS), .WIDTH(WIDTH)) UUT (
		.clk(clk), .rst(rst), .peripheralEnable(peripheralEnable), .busWe(busWe),
		.busOe(busOe), .busAddress(busAddress), .busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite), .busDataRead(busDataRead),
		.requestOutput(requestOutput), .pwmEn(pwmEn), .pwmOut(pwmOut), .irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
			abortRun("value mismatch");
		end
	endtask

	function automatic logic [31:0] mergeLanes(input logic [31:0] old,
		input logic [31:0] data, input logic [3:0] mask);
		logic [31:0] result;
		result = old;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				result[8*b +: 8] = data[8*b +: 8];
			end
		end
		return result;
	endfunction

	// channel index of a compare address, -1 for anything else
	function automatic int compareIndex(input logic [11:0] localAddr);
		if (localAddr < addrCompareBase || localAddr[1:0] != 2'b00) return -1;
		if ((localAddr - addrCompareBase) / addrCompareStride >= OUTPUTS) return -1;
		return (localAddr - addrCompareBase) / addrCompareStride;
	endfunction

	function automatic bit expectRead(input logic [15:0] addr, output logic [31:0] value);
		int index;
		index = compareIndex(addr[11:0]);
		value = readIdle;
		if (addr[15:12] != ID) return 0;
		if (addr[11:0] == addrConfig) value = shadowConfig;
		else if (addr[11:0] == addrTop) value = shadowTop;
		else if (index >= 0) value = shadowCompare[index];
		else return 0;
		return 1;
	endfunction

	// one clock, then pin checks against the model
	task automatic tick();
		@(posedge clk);
		#5;
		lastRise = pwmOut & ~prevPwm;
		checkValue("pwmEn", shadowConfig[9:6] & shadowConfig[13:10], pwmEn);
		checkValue("irq", |((shadowConfig[17:14] & lastRise)
			| (shadowConfig[21:18] & prevPwm & ~pwmOut)), irq);
		prevPwm = pwmOut;
	endtask

	task automatic idleBus();
		peripheralEnable = 1'b0;
		busWe = 1'b0;
		busOe = 1'b0;
		busAddress = '0;
		busByteSelect = '0;
		busDataWrite = '0;
	endtask

	task automatic busWrite(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		int index;
		tick();
		peripheralEnable = 1'b1;
		busWe = 1'b1;
		busAddress = addr;
		busByteSelect = mask;
		busDataWrite = data;
		index = compareIndex(addr[11:0]);
		if (addr[15:12] == ID) begin
			if (addr[11:0] == addrConfig) begin
				shadowConfig = mergeLanes(shadowConfig, data, mask) & configMask;
			end else if (addr[11:0] == addrTop) begin
				shadowTop = mergeLanes(shadowTop, data, mask) & 32'h0000_ffff;
			end else if (index >= 0) begin
				shadowCompare[index] = mergeLanes(shadowCompare[index], data, mask) & 32'h0000_ffff;
			end
		end
		tick();
		idleBus();
	endtask

	task automatic busRead(input logic [15:0] addr, input string expTok);
		logic [31:0] got;
		logic [31:0] expected;
		logic [31:0] fileValue;
		logic gotRequest;
		bit mapped;
		tick();
		peripheralEnable = 1'b1;
		busOe = 1'b1;
		busAddress = addr;
		#20;
		got = busDataRead;
		gotRequest = requestOutput;
		if (addr[15:12] == ID && addr[11:0] == addrData) begin
			checkValue("requestOutput", 1'b1, gotRequest);
			assert (got[WIDTH-1:0] <= shadowTop[WIDTH-1:0]) else
				abortRun($sformatf("data register count %h is above top %h", got[WIDTH-1:0],
					shadowTop[WIDTH-1:0]));
		end else begin
			mapped = expectRead(addr, expected);
			checkValue("requestOutput", mapped, gotRequest);
			checkValue("busDataRead", expected, got);
		end
		if (expTok != "-") begin
			void'($sscanf(expTok, "%h", fileValue));
			checkValue("busDataRead", fileValue, got);
		end
		tick();
		idleBus();
	endtask

	task automatic waitRise(input int channel, input int limit);
		int waited;
		tick();
		waited = 1;
		while (!lastRise[channel] && waited < limit) begin
			tick();
			waited++;
		end
		if (!lastRise[channel])
			abortRun($sformatf("pwmOut[%0d] never rose within %0d cycles", channel, limit));
	endtask

	// duty and period over whole periods, starting at a rise of the reference channel
	task automatic runWaveform(input int channel, input int periods, input string expTok);
		int period;
		int gap;
		int shift;
		int highs [OUTPUTS];
		logic [31:0] filePeriod;
		logic [31:0] duty;
		shift = shadowConfig[scaleWidth-1:0];
		period = (shadowTop + 1) << shift;
		void'($sscanf(expTok, "%h", filePeriod));
		checkValue("period in data file", period, filePeriod);
		waitRise(channel, 2 * period + 8);
		gap = 0;
		for (int i = 0; i < OUTPUTS; i++) highs[i] = pwmOut[i];
		for (int k = 1; k < periods * period; k++) begin
			tick();
			for (int i = 0; i < OUTPUTS; i++) highs[i] += pwmOut[i];
			if (lastRise[channel] && gap == 0) gap = k;
		end
		if (gap == 0) abortRun("no second rise inside the measured window");
		checkValue("rise period", period, gap);
		for (int i = 0; i < OUTPUTS; i++) begin
			duty = (shadowCompare[i] > shadowTop) ? shadowTop + 1 : shadowCompare[i];
			checkValue($sformatf("pwmOut[%0d] high cycles", i),
				shadowConfig[6 + i] ? periods * (duty << shift) : 0, highs[i]);
		end
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		string op;
		string expTok;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] mask;
		void'($urandom(32'haa43));
		idleBus();
		rst = 1'b1;
		prevPwm = '0;
		lastRise = '0;
		shadowConfig = defaultScale;
		shadowTop = defaultTop;
		for (int i = 0; i < OUTPUTS; i++) shadowCompare[i] = '0;
		repeat (16) @(posedge clk);
		#5 rst = 1'b0;
		checkValue("pwmOut", '0, pwmOut);
		fd = $fopen("testbench/pwmDeviceInput.txt", "r");
		if (fd == 0) abortRun("cannot open testbench/pwmDeviceInput.txt");
		while ($fgets(line, fd)) begin
			fields = $sscanf(line, "%s %h %h %h %s", op, addr, data, mask, expTok);
			if (fields < 5 || op[0] == "#") continue;
			case (op)
				"write": busWrite(addr[15:0], data, mask[3:0]);
				"randomwrite": busWrite(addr[15:0], $urandom, 4'($urandom));
				"read": busRead(addr[15:0], expTok);
				"run": runWaveform(addr, data, expTok);
				default: abortRun({"unknown opcode in data file: ", op});
			endcase
		end
		$fclose(fd);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* testbench/pwmDeviceInput.txt */
# opcode address data mask expected, all numbers hex, expected "-" means model only
# run: address is the reference channel, data the period count, expected the period in clocks
read 3000 0 0 00000003
read 3004 0 0 00001387
read 3010 0 0 00000000
read 301c 0 0 00000000
write 3004 0000aa55 1 -
read 3004 0 0 00001355
write 3004 000012ff 2 -
read 3004 0 0 00001255
write 5004 ffffffff f -
read 3004 0 0 00001255
write 3000 ffffffff 8 -
read 3000 0 0 00000003
write 3000 00ff0007 5 -
read 3000 0 0 003f0007
write 3014 12345678 3 -
write 3014 ffff9abc 2 -
read 3014 0 0 00009a78
randomwrite 3018 0 0 -
read 3018 0 0 -
read 3020 0 0 ffffffff
read 300c 0 0 ffffffff
read 5000 0 0 ffffffff
write 3004 00000009 f -
write 3010 00000003 f -
write 3014 00000005 f -
write 3018 00000000 f -
write 301c 0000000c f -
write 3000 00087fe0 f -
read 3000 0 0 00087fe0
run 0 a 0 a
write 3000 00087fe2 f -
run 1 3 0 28
read 3008 0 0 -
read 3008 0 0 -
write 3000 000017e0 f -
run 0 2 0 a
write 3000 003fd7e0 f -
run 0 2 0 a
write 3000 00003ce0 f -
run 0 2 0 a

/* pwmDevice.f */
logic/pwmPkg.sv
logic/busRegister.sv
logic/pwmTimebase.sv
logic/pwmChannel.sv
logic/pwmBusInterface.sv
logic/pwmDevice.sv
testbench/pwmDeviceTb.sv

/* Bender.yml */
package:
  name: pwm_device

sources:
  - logic/pwmPkg.sv
  - logic/busRegister.sv
  - logic/pwmTimebase.sv
  - logic/pwmChannel.sv
  - logic/pwmBusInterface.sv
  - logic/pwmDevice.sv
  - target: test
    files:
      - testbench/pwmDeviceTb.sv
